/* common/gfx_pkg.sv */
/*
 * graphics data types
 * pixel values and the rom word and address seen by the fetcher
 */
`default_nettype none
`include "linebuf_config.svh"

package gfx_pkg;

    // one pixel as stored in the line buffer
    typedef logic [`LB_PW-1:0] pixel_t;

    // rom word address
    typedef logic [`LB_AW-1:0] rom_addr_t;

    // rom word, pixel 0 in the low byte
    typedef logic [`LB_RW-1:0] rom_data_t;

endpackage

`default_nettype wire

/* common/linebuf_config.svh */
/*
 * line buffer stage configuration
 * widths and line timing for the video timer, fetcher and line buffer gate
 */
`ifndef LINEBUF_CONFIG_SVH
`define LINEBUF_CONFIG_SVH

// widths
`define LB_HW       9       // horizontal count and line buffer address
`define LB_VW       9       // vertical count
`define LB_PW       8       // one pixel
`define LB_RW       32      // rom word, four pixels packed
`define LB_AW       16      // rom word address

// line timing, counted in write counter steps
`define LB_RST_CT   8       // write counter start value
`define LB_B_VIS    4       // steps before the visible window
`define LB_VIS      32      // visible pixels per line
`define LB_A_VIS    4       // steps after the visible window
`define LB_HTOT     64      // pixel enables per line
`define LB_RD_DLY   3       // hdump delay to the read address
`define LB_HS_END   6       // hs high for hdump below this

// frame timing
`define LB_VTOT     24      // lines per frame
`define LB_VB_END   19      // last blank line

`endif

/* common/rom_if.sv */
/*
 * rom request bus
 * chip select and address out, ready and data back
 */
`timescale 1ns/1ps
`default_nettype none

interface rom_if;
    logic                rom_cs;     // request pending
    gfx_pkg::rom_addr_t  rom_addr;   // held while rom_cs and not rom_ok
    logic                rom_ok;     // data valid, request done
    gfx_pkg::rom_data_t  rom_data;

    modport fetcher (
        output rom_cs, rom_addr,
        input  rom_ok, rom_data
    );

    modport top (
        input  rom_cs, rom_addr,
        output rom_ok, rom_data
    );
endinterface

`default_nettype wire

/* common/video_pkg.sv */
/*
 * video timing types
 * horizontal and vertical counts shared by the timer and the line buffer
 */
`default_nettype none
`include "linebuf_config.svh"

package video_pkg;

    // horizontal count, also used as line buffer address
    typedef logic [`LB_HW-1:0] hcnt_t;

    // vertical count
    typedef logic [`LB_VW-1:0] vcnt_t;

endpackage

`default_nettype wire

/* linebuf/line_buffer.sv */
/*
 * ping-pong line memory
 * one bank is written while the other is read, swapped at hs falling edge
 */
`timescale 1ns/1ps
`default_nettype none
`include "linebuf_config.svh"

module line_buffer (
    input  logic              clk,
    input  logic              hs,
    input  logic              we,
    input  video_pkg::hcnt_t  wr_addr,
    input  gfx_pkg::pixel_t   wr_data,
    input  video_pkg::hcnt_t  rd_addr,
    output gfx_pkg::pixel_t   rd_data
);
    localparam int DEPTH = 1 << `LB_HW;

    gfx_pkg::pixel_t mem_a [DEPTH];
    gfx_pkg::pixel_t mem_b [DEPTH];
    logic            hs_l = 1'b0;
    logic            bank = 1'b0;       // 0 writes bank a and reads bank b

    always_ff @(posedge clk) begin
        hs_l <= hs;
        if (hs_l && !hs) bank <= ~bank; // new line, swap roles
    end

    always_ff @(posedge clk) begin
        if (we && !bank) mem_a[wr_addr] <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (we && bank) mem_b[wr_addr] <= wr_data;
    end

    // registered read from the bank filled during the previous line
    always_ff @(posedge clk) begin
        rd_data <= bank ? mem_a[rd_addr] : mem_b[rd_addr];
    end

endmodule

`default_nettype wire

/* linebuf/linebuf_gate.sv */
/*
 * line buffer gate
 * paces the write counter against rom readiness, delays hdump into the
 * read address and holds the ping-pong line memory
 */
`timescale 1ns/1ps
`default_nettype none
`include "linebuf_config.svh"

module linebuf_gate (
    input  logic              clk,
    input  logic              reset,
    input  logic              cen,
    input  logic              pxl_cen,
    input  logic              lvbl,
    input  logic              hs,
    input  video_pkg::vcnt_t  vdump,
    input  video_pkg::hcnt_t  hdump,
    input  logic              we,
    input  gfx_pkg::pixel_t   pxl_data,
    input  logic              rom_cs,
    input  logic              rom_ok,
    output logic              cnt_cen,
    output video_pkg::hcnt_t  wr_addr,
    output gfx_pkg::pixel_t   pxl_dump
);
    localparam video_pkg::hcnt_t RST_CT  = video_pkg::hcnt_t'(`LB_RST_CT);
    localparam video_pkg::hcnt_t WR_STRT = RST_CT + video_pkg::hcnt_t'(`LB_B_VIS);
    localparam video_pkg::hcnt_t WR_END  = WR_STRT + video_pkg::hcnt_t'(`LB_VIS);
    localparam video_pkg::hcnt_t RD_END  = WR_END + video_pkg::hcnt_t'(`LB_A_VIS);
    localparam video_pkg::hcnt_t HEND    = RST_CT + video_pkg::hcnt_t'(`LB_HTOT);
    localparam video_pkg::vcnt_t VB_END  = video_pkg::vcnt_t'(`LB_VB_END);

    logic              hs_l;        // hs seen on the last cen
    logic              hs_fall;
    logic              reload;      // restart the write counter
    logic              last_line;
    logic              done;
    logic              fastwr;      // free run, no rom to wait for
    logic              rd_vis;      // read data belongs to the visible window
    video_pkg::hcnt_t  rd_dly [`LB_RD_DLY];
    video_pkg::hcnt_t  rd_addr;
    gfx_pkg::pixel_t   buf_data;

    assign last_line = vdump == VB_END;
    assign hs_fall   = cen && hs_l && !hs;
    assign reload    = hs_fall && (lvbl || last_line);  // fill starts one line ahead
    assign done      = wr_addr >= RD_END;

    // outside the window there is nothing to fetch, so run at full rate
    assign fastwr = (wr_addr < WR_STRT)
                 || (wr_addr >= WR_END && wr_addr < RD_END)
                 || (hs && wr_addr < HEND);             // keeps pulses going during hs

    // inside the window a pending rom request holds the counter
    assign cnt_cen = cen && (fastwr || ((!rom_cs || rom_ok) && !done));

    always_ff @(posedge clk) begin
        if (reset) begin
            hs_l <= 1'b0;
        end else if (cen) begin
            hs_l <= hs;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_addr <= RD_END;              // idle until the first reload
        end else if (reload) begin
            wr_addr <= RST_CT;
        end else if (cnt_cen) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    // hdump delay line, one stage per pixel enable
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `LB_RD_DLY; i++) rd_dly[i] <= '0;
        end else if (pxl_cen) begin
            rd_dly[0] <= hdump;
            for (int i = 1; i < `LB_RD_DLY; i++) rd_dly[i] <= rd_dly[i-1];
        end
    end

    assign rd_addr = rd_dly[`LB_RD_DLY-1];

    // window flag lines up with the registered ram read
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_vis <= 1'b0;
        end else begin
            rd_vis <= rd_addr >= WR_STRT && rd_addr < WR_END;
        end
    end

    assign pxl_dump = rd_vis ? buf_data : '0;   // blank outside the window

    line_buffer u_line_buffer (
        .clk     ( clk      ),
        .hs      ( hs       ),
        .we      ( we       ),
        .wr_addr ( wr_addr  ),
        .wr_data ( pxl_data ),
        .rd_addr ( rd_addr  ),
        .rd_data ( buf_data )
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the line buffer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f vlog.f --top-module linebuf_tb -o linebuf_sim || exit 1
out=$(./obj_dir/linebuf_sim)
echo "$out"
echo "$out" | grep -qx "Done: no errors" && exit 0 || exit 1

/* source/linebuf_top.sv */
/*
 * scan-line buffer stage
 * video timer, rom pixel fetcher and line buffer gate
 */
`timescale 1ns/1ps
`default_nettype none

module linebuf_top (
    input  logic                clk,
    input  logic                reset,
    output logic                rom_cs,
    output gfx_pkg::rom_addr_t  rom_addr,
    input  logic                rom_ok,
    input  gfx_pkg::rom_data_t  rom_data,
    output video_pkg::hcnt_t    hdump,
    output video_pkg::vcnt_t    vdump,
    output logic                hs,
    output logic                lvbl,
    output logic                pxl_cen,
    output gfx_pkg::pixel_t     pxl_dump
);
    logic              cen;
    logic              cnt_cen;     // one write step
    logic              we;
    video_pkg::hcnt_t  wr_addr;
    gfx_pkg::pixel_t   pxl_data;

    rom_if rom_bus ();

    // rom bus out to plain ports
    assign rom_cs           = rom_bus.rom_cs;
    assign rom_addr         = rom_bus.rom_addr;
    assign rom_bus.rom_ok   = rom_ok;
    assign rom_bus.rom_data = rom_data;

    video_timer u_video_timer (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .cen     ( cen     ),
        .pxl_cen ( pxl_cen ),
        .hdump   ( hdump   ),
        .vdump   ( vdump   ),
        .hs      ( hs      ),
        .lvbl    ( lvbl    )
    );

    pixel_fetcher u_pixel_fetcher (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .cnt_cen  ( cnt_cen  ),
        .wr_addr  ( wr_addr  ),
        .vdump    ( vdump    ),
        .rom      ( rom_bus  ),
        .we       ( we       ),
        .pxl_data ( pxl_data )
    );

    linebuf_gate u_linebuf_gate (
        .clk      ( clk             ),
        .reset    ( reset           ),
        .cen      ( cen             ),
        .pxl_cen  ( pxl_cen         ),
        .lvbl     ( lvbl            ),
        .hs       ( hs              ),
        .vdump    ( vdump           ),
        .hdump    ( hdump           ),
        .we       ( we              ),
        .pxl_data ( pxl_data        ),
        .rom_cs   ( rom_bus.rom_cs  ),
        .rom_ok   ( rom_bus.rom_ok  ),
        .cnt_cen  ( cnt_cen         ),
        .wr_addr  ( wr_addr         ),
        .pxl_dump ( pxl_dump        )
    );

endmodule

`default_nettype wire

/* source/pixel_fetcher.sv */
/*
 * pixel fetcher
 * requests rom words for the visible window and unpacks four pixels per word
 */
`timescale 1ns/1ps
`default_nettype none
`include "linebuf_config.svh"

module pixel_fetcher (
    input  logic              clk,
    input  logic              reset,
    input  logic              cnt_cen,
    input  video_pkg::hcnt_t  wr_addr,
    input  video_pkg::vcnt_t  vdump,
    rom_if.fetcher            rom,
    output logic              we,
    output gfx_pkg::pixel_t   pxl_data
);
    localparam video_pkg::hcnt_t WR_STRT = video_pkg::hcnt_t'(`LB_RST_CT + `LB_B_VIS);
    localparam video_pkg::hcnt_t WR_END  = WR_STRT + video_pkg::hcnt_t'(`LB_VIS);
    localparam gfx_pkg::rom_addr_t WORDS_PL = gfx_pkg::rom_addr_t'(`LB_VIS / 4);

    gfx_pkg::rom_data_t  held_word;     // last word from the rom
    gfx_pkg::rom_addr_t  word_tag;      // its address
    logic                word_vld;
    logic                in_win;
    logic                hit;           // held word covers this pixel
    video_pkg::hcnt_t    x;             // offset into the window
    logic [1:0]          px_idx;        // pixel inside the word
    gfx_pkg::rom_addr_t  req_addr;
    gfx_pkg::rom_data_t  cur_word;

    assign in_win   = wr_addr >= WR_STRT && wr_addr < WR_END;
    assign x        = wr_addr - WR_STRT;
    assign px_idx   = x[1:0];
    assign req_addr = gfx_pkg::rom_addr_t'(vdump) * WORDS_PL
                    + gfx_pkg::rom_addr_t'(x >> 2);
    assign hit      = word_vld && word_tag == req_addr;

    // wr_addr is frozen while waiting, so the address holds until rom_ok
    assign rom.rom_cs   = in_win && !hit;
    assign rom.rom_addr = req_addr;

    // on the rom_ok cycle the pixel comes straight from the bus
    assign cur_word = hit ? held_word : rom.rom_data;
    assign we       = cnt_cen;
    assign pxl_data = in_win ? cur_word[px_idx*`LB_PW +: `LB_PW] : '0;  // clear outside

    always_ff @(posedge clk) begin
        if (reset) begin
            word_vld <= 1'b0;
        end else if (rom.rom_cs && rom.rom_ok) begin
            word_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rom.rom_cs && rom.rom_ok) begin
            held_word <= rom.rom_data;
            word_tag  <= req_addr;
        end
    end

endmodule

`default_nettype wire

/* source/video_timer.sv */
/*
 * video timer
 * pixel enable, horizontal and vertical counters, hsync and vblank
 */
`timescale 1ns/1ps
`default_nettype none
`include "linebuf_config.svh"

module video_timer (
    input  logic              clk,
    input  logic              reset,
    output logic              cen,
    output logic              pxl_cen,
    output video_pkg::hcnt_t  hdump,
    output video_pkg::vcnt_t  vdump,
    output logic              hs,
    output logic              lvbl
);
    localparam video_pkg::hcnt_t H_LAST = video_pkg::hcnt_t'(`LB_HTOT - 1);
    localparam video_pkg::vcnt_t V_LAST = video_pkg::vcnt_t'(`LB_VTOT - 1);
    localparam video_pkg::hcnt_t HS_END = video_pkg::hcnt_t'(`LB_HS_END);
    localparam video_pkg::vcnt_t VB_END = video_pkg::vcnt_t'(`LB_VB_END);

    video_pkg::hcnt_t h_next;   // count after this pixel enable
    video_pkg::vcnt_t v_next;

    assign cen = 1'b1;          // logic runs at full clock rate

    always_comb begin
        h_next = hdump + 1'b1;
        v_next = vdump;
        if (hdump == H_LAST) begin
            h_next = '0;                                        // end of line
            v_next = (vdump == V_LAST) ? '0 : vdump + 1'b1;     // next line or frame wrap
        end
    end

    // hs and lvbl follow the next count so they stay aligned with hdump/vdump
    always_ff @(posedge clk) begin
        if (reset) begin
            pxl_cen <= 1'b0;
            hdump   <= '0;
            vdump   <= '0;
            hs      <= 1'b0;
            lvbl    <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;                // every second clock
            if (pxl_cen) begin
                hdump <= h_next;
                vdump <= v_next;
                hs    <= h_next < HS_END;       // sync at start of line
                lvbl  <= v_next > VB_END;       // blank up to VB_END
            end
        end
    end

endmodule

`default_nettype wire

/* verification/linebuf_tb.sv */
/*
 * line buffer stage testbench
 * reset check and two directed frame runs against a random latency rom
 */
`timescale 1ns/1ps
`default_nettype none
`include "linebuf_config.svh"

module linebuf_tb;
    localparam int FRAME_CYC = `LB_HTOT * `LB_VTOT * 2;    // clocks per frame
    localparam int LIMIT     = 3 * FRAME_CYC;
    localparam int WIN_LO    = `LB_RST_CT + `LB_B_VIS;     // first visible address
    localparam int WIN_HI    = WIN_LO + `LB_VIS;

    logic                clk = 1'b0;
    logic                reset;
    logic                rom_cs;
    gfx_pkg::rom_addr_t  rom_addr;
    logic                rom_ok;
    gfx_pkg::rom_data_t  rom_data;
    video_pkg::hcnt_t    hdump;
    video_pkg::vcnt_t    vdump;
    logic                hs;
    logic                lvbl;
    logic                pxl_cen;
    gfx_pkg::pixel_t     pxl_dump;

    int                  errors = 0;
    int                  checks = 0;
    int                  cycles = 0;
    int                  exp_h;                     // expected counts
    int                  exp_v;
    logic                exp_pcen;                  // expected pixel enable phase
    logic                hs_live;                   // hs tracks hdump after the first step
    int                  rd_pipe [`LB_RD_DLY];      // hdump delayed to the read address
    logic                prev_cs;                   // rom bus one cycle back
    logic                prev_ok;
    gfx_pkg::rom_addr_t  prev_addr;

    always #4 clk = ~clk;

    linebuf_top dut_i (.*);

    rom_model rom_i (.*);

    // pixel x of line v as packed in rom, four per word
    function automatic gfx_pkg::pixel_t exp_pixel(input int v, input int x);
        int word;
        word = v * (`LB_VIS / 4) + x / 4;
        return gfx_pkg::pixel_t'(word * 4 + x % 4);
    endfunction

    task automatic check_pixel(input string name, input gfx_pkg::pixel_t exp,
                               input gfx_pkg::pixel_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s pxl_dump: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input video_pkg::hcnt_t exp,
                               input video_pkg::hcnt_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s hdump: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_line(input string name, input video_pkg::vcnt_t exp,
                              input video_pkg::vcnt_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s vdump: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_rom_addr(input string name, input gfx_pkg::rom_addr_t exp,
                                  input gfx_pkg::rom_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s rom_addr held: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // one clock sampled mid-cycle where all outputs have settled
    task automatic sample_cycle(input string name);
        int rd;
        @(negedge clk);
        if (prev_cs && !prev_ok) begin                  // request still open
            if (rom_cs !== 1'b1) begin
                errors++;
                $display("%s: rom_cs dropped before rom_ok in cycle %0d", name, cycles);
            end else begin
                check_rom_addr(name, prev_addr, rom_addr);
            end
        end
        prev_cs   = rom_cs;
        prev_ok   = rom_ok;
        prev_addr = rom_addr;
        check_flag({name, " pxl_cen"}, exp_pcen, pxl_cen);
        if (exp_pcen) begin                             // counts move at the next edge
            check_count(name, video_pkg::hcnt_t'(exp_h), hdump);
            check_line(name, video_pkg::vcnt_t'(exp_v), vdump);
            check_flag({name, " lvbl"}, exp_v > `LB_VB_END, lvbl);
            check_flag({name, " hs"}, hs_live && exp_h < `LB_HS_END, hs);
            rd = rd_pipe[`LB_RD_DLY-1];
            if (rd < WIN_LO || rd >= WIN_HI) begin
                check_pixel(name, '0, pxl_dump);       // blank outside the window
            end else if (exp_v > `LB_VB_END) begin
                check_pixel(name, exp_pixel(exp_v - 1, rd - WIN_LO), pxl_dump);
            end
            for (int i = `LB_RD_DLY - 1; i > 0; i--) begin
                rd_pipe[i] = rd_pipe[i-1];
            end
            rd_pipe[0] = exp_h;
            exp_h = (exp_h + 1) % `LB_HTOT;
            if (exp_h == 0) begin
                exp_v = (exp_v + 1) % `LB_VTOT;     // new line
            end
            hs_live = 1'b1;
        end
        exp_pcen = !exp_pcen;
    endtask

    task automatic apply_reset(input string name);
        reset = 1'b1;
        repeat (15) @(posedge clk);
        @(negedge clk);                                 // state while reset holds
        check_flag({name, " rom_cs"}, 1'b0, rom_cs);
        check_count(name, '0, hdump);
        check_line(name, '0, vdump);
        check_flag({name, " lvbl"}, 1'b0, lvbl);
        @(posedge clk);
        #1;
        reset     = 1'b0;
        exp_h     = 0;
        exp_v     = 0;
        exp_pcen  = 1'b0;
        hs_live   = 1'b0;
        prev_cs   = 1'b0;
        prev_ok   = 1'b0;
        prev_addr = '0;
        for (int i = 0; i < `LB_RD_DLY; i++) begin
            rd_pipe[i] = 0;
        end
    endtask

    task automatic run_frame(input string name);
        repeat (FRAME_CYC) sample_cycle(name);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        apply_reset("reset");
        run_frame("frame_1");
        run_frame("frame_2");                           // reload and bank swap recover
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/rom_model.sv */
/*
 * rom responder for the fetcher
 * answers rom_cs after a random wait, each byte follows its address
 */
`timescale 1ns/1ps
`default_nettype none
`include "linebuf_config.svh"

module rom_model (
    input  logic                clk,
    input  logic                reset,
    input  logic                rom_cs,
    input  gfx_pkg::rom_addr_t  rom_addr,
    output logic                rom_ok,
    output gfx_pkg::rom_data_t  rom_data
);
    integer              seed = 32'h9d92;
    logic                pending;       // request seen, not yet answered
    logic                nxt_ok;
    int                  wait_left;     // extra cycles before rom_ok
    gfx_pkg::rom_addr_t  req_addr;

    // byte i of word a holds the low bits of a*4+i
    function automatic gfx_pkg::rom_data_t word_at(input gfx_pkg::rom_addr_t addr);
        gfx_pkg::rom_data_t w;
        for (int i = 0; i < 4; i++) begin
            w[i*`LB_PW +: `LB_PW] = gfx_pkg::pixel_t'(int'(addr) * 4 + i);
        end
        return w;
    endfunction

    initial begin
        rom_ok    = 1'b0;
        rom_data  = '0;
        pending   = 1'b0;
        wait_left = 0;
        req_addr  = '0;
        forever begin
            @(negedge clk);                         // bus is settled mid-cycle
            nxt_ok = 1'b0;
            if (reset || !rom_cs || rom_ok) begin
                pending = 1'b0;                     // idle, or done at the next edge
            end else begin
                if (!pending) begin
                    pending   = 1'b1;
                    req_addr  = rom_addr;
                    wait_left = {$random(seed)} % 6;    // 0 to 5 extra cycles
                end
                if (wait_left == 0) begin
                    nxt_ok = 1'b1;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
            @(posedge clk);
            #1;
            rom_ok   = nxt_ok;
            rom_data = nxt_ok ? word_at(req_addr) : {4{8'ha5}};    // junk unless rom_ok
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
common/video_pkg.sv
common/gfx_pkg.sv
common/rom_if.sv
source/video_timer.sv
linebuf/line_buffer.sv
linebuf/linebuf_gate.sv
source/pixel_fetcher.sv
source/linebuf_top.sv
verification/rom_model.sv
verification/linebuf_tb.sv
